//--- Makefile
SIM      := verilator
TOP      := sound_unit_tb
FILELIST := sound_unit.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
RUN_ARGS := +verilator+error+limit+100
PASS_MSG := Finished with no errors
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- hw/noise_lfsr.sv
/*
 * Noise source
 *   rate counter, same reload scheme as the tone oscillator
 *   15 bit Fibonacci LFSR stepped at each expiry
 *   noise is the LFSR low bit
 */
`default_nettype none

module noise_lfsr (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             tick,
    input  logic [sound_bus_pkg::freq_w-1:0] rate,   // ticks per step minus one
    output logic                             noise
);
    import sound_bus_pkg::*;
    import sound_synth_pkg::*;

    localparam logic [lfsr_w-1:0] lfsr_seed = 15'h0001;  // any nonzero value

    logic [freq_w-1:0] cnt;
    logic [lfsr_w-1:0] lfsr;
    logic              feedback;

    assign feedback = ^(lfsr & lfsr_taps);     // xor of tapped bits
    assign noise    = lfsr[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= '0;
            lfsr <= lfsr_seed;                 // all zero would lock up
        end else if (tick) begin
            if (cnt == '0) begin
                cnt  <= rate;
                lfsr <= {lfsr[lfsr_w-2:0], feedback};   // shift up, new bit at 0
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/sound_bus_pkg.sv
/*
 * Bus side definitions of the sound unit
 *   bus address and data widths
 *   register address map, 0x00 to 0x0a
 *   stored field widths of each register
 */
`default_nettype none

package sound_bus_pkg;

    localparam int addr_w = 8;                       // register bus address
    localparam int data_w = 8;                       // register bus data

    // byte addresses, lo byte before hi byte
    localparam logic [addr_w-1:0] addr_vco1_lo  = 8'h00;
    localparam logic [addr_w-1:0] addr_vco1_hi  = 8'h01;
    localparam logic [addr_w-1:0] addr_vco2_lo  = 8'h02;
    localparam logic [addr_w-1:0] addr_vco2_hi  = 8'h03;
    localparam logic [addr_w-1:0] addr_noise_lo = 8'h04;
    localparam logic [addr_w-1:0] addr_noise_hi = 8'h05;
    localparam logic [addr_w-1:0] addr_lfo_lo   = 8'h06;
    localparam logic [addr_w-1:0] addr_lfo_hi   = 8'h07;
    localparam logic [addr_w-1:0] addr_depth    = 8'h08;   // lfo modulation depth
    localparam logic [addr_w-1:0] addr_mod_sel  = 8'h09;   // {noise, vco2, vco1}
    localparam logic [addr_w-1:0] addr_mixer    = 8'h0a;   // {lfo, noise, vco2, vco1}

    // field widths, hi bytes keep only the bits above 7
    localparam int freq_w     = 12;                  // vco and noise half period
    localparam int lfo_freq_w = 10;                  // lfo half period
    localparam int depth_w    = 3;                   // right shift of the stretch term
    localparam int mod_w      = 3;                   // one bit per modulated source
    localparam int mix_w      = 4;                   // one bit per mixed source

endpackage

`default_nettype wire

//--- hw/sound_regs.sv
/*
 * Register file of the sound unit
 *   eleven byte mapped fields, write decode per address
 *   combinational readback, zero when re is low or unmapped
 *   decoded fields out to the synthesizer
 */
`default_nettype none

module sound_regs (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic [sound_bus_pkg::addr_w-1:0]       addr,
    input  logic [sound_bus_pkg::data_w-1:0]       data_in,
    input  logic                                   re,
    input  logic                                   we,
    output logic [sound_bus_pkg::data_w-1:0]       data_out,
    output logic [sound_bus_pkg::freq_w-1:0]       vco1_freq,
    output logic [sound_bus_pkg::freq_w-1:0]       vco2_freq,
    output logic [sound_bus_pkg::freq_w-1:0]       noise_freq,
    output logic [sound_bus_pkg::lfo_freq_w-1:0]   lfo_freq,
    output logic [sound_bus_pkg::depth_w-1:0]      lfo_depth,
    output logic [sound_bus_pkg::mod_w-1:0]        mod_select,
    output logic [sound_bus_pkg::mix_w-1:0]        mixer
);
    import sound_bus_pkg::*;

    // write side, data bits above the field are dropped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vco1_freq  <= '0;
            vco2_freq  <= '0;
            noise_freq <= '0;
            lfo_freq   <= '0;
            lfo_depth  <= '0;
            mod_select <= '0;
            mixer      <= '0;
        end else if (we) begin
            case (addr)
                addr_vco1_lo:  vco1_freq[7:0]          <= data_in;
                addr_vco1_hi:  vco1_freq[freq_w-1:8]   <= data_in[freq_w-9:0];
                addr_vco2_lo:  vco2_freq[7:0]          <= data_in;
                addr_vco2_hi:  vco2_freq[freq_w-1:8]   <= data_in[freq_w-9:0];
                addr_noise_lo: noise_freq[7:0]         <= data_in;
                addr_noise_hi: noise_freq[freq_w-1:8]  <= data_in[freq_w-9:0];
                addr_lfo_lo:   lfo_freq[7:0]           <= data_in;
                addr_lfo_hi:   lfo_freq[lfo_freq_w-1:8] <= data_in[lfo_freq_w-9:0];
                addr_depth:    lfo_depth               <= data_in[depth_w-1:0];
                addr_mod_sel:  mod_select              <= data_in[mod_w-1:0];
                addr_mixer:    mixer                   <= data_in[mix_w-1:0];
                default: ;                               // 0x0b and up, no effect
            endcase
        end
    end

    // read side, same cycle as re
    always_comb begin
        data_out = '0;
        if (re) begin
            case (addr)
                addr_vco1_lo:  data_out = vco1_freq[7:0];
                addr_vco1_hi:  data_out = data_w'(vco1_freq[freq_w-1:8]);
                addr_vco2_lo:  data_out = vco2_freq[7:0];
                addr_vco2_hi:  data_out = data_w'(vco2_freq[freq_w-1:8]);
                addr_noise_lo: data_out = noise_freq[7:0];
                addr_noise_hi: data_out = data_w'(noise_freq[freq_w-1:8]);
                addr_lfo_lo:   data_out = lfo_freq[7:0];
                addr_lfo_hi:   data_out = data_w'(lfo_freq[lfo_freq_w-1:8]);
                addr_depth:    data_out = data_w'(lfo_depth);
                addr_mod_sel:  data_out = data_w'(mod_select);
                addr_mixer:    data_out = data_w'(mixer);
                default:       data_out = '0;    // unmapped reads as zero
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/sound_synth.sv
/*
 * Sound synthesizer core
 *   tick generator, one pulse every prescale clk cycles
 *   LFO stretch of the VCO and noise periods
 *   VCO1, VCO2, LFO oscillators and the noise LFSR
 *   registered XOR mixer driving signal_out
 */
`default_nettype none

module sound_synth #(
    parameter int prescale = sound_synth_pkg::prescale_default
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic [sound_bus_pkg::freq_w-1:0]     vco1_freq,
    input  logic [sound_bus_pkg::freq_w-1:0]     vco2_freq,
    input  logic [sound_bus_pkg::freq_w-1:0]     noise_freq,
    input  logic [sound_bus_pkg::lfo_freq_w-1:0] lfo_freq,
    input  logic [sound_bus_pkg::depth_w-1:0]    lfo_depth,
    input  logic [sound_bus_pkg::mod_w-1:0]      mod_select,
    input  logic [sound_bus_pkg::mix_w-1:0]      mixer,
    output logic                                 signal_out
);
    import sound_bus_pkg::*;
    import sound_synth_pkg::*;

    localparam int pre_w = (prescale > 1) ? $clog2(prescale) : 1;

    logic [pre_w-1:0]  pre_cnt;
    logic              tick;
    logic              vco1_wave, vco2_wave, lfo_wave, noise_bit;
    logic [freq_w-1:0] vco1_period, vco2_period, noise_rate;
    logic [mix_w-1:0]  src_bits;                 // indexed by src_* positions

    // freq plus freq >> depth while selected and lfo high, clamped on carry
    function automatic logic [freq_w-1:0] mod_period(
        input logic [freq_w-1:0]  freq,
        input logic [depth_w-1:0] depth,
        input logic               sel,
        input logic               lfo
    );
        logic [freq_w:0] sum;
        sum = {1'b0, freq} + {1'b0, freq >> depth};
        if (!(sel && lfo))
            return freq;
        if (sum[freq_w])
            return '1;
        return sum[freq_w-1:0];
    endfunction

    // tick gen, counter from zero after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pre_cnt <= '0;
            tick    <= 1'b0;
        end else if (pre_cnt == pre_w'(prescale - 1)) begin
            pre_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

    assign vco1_period = mod_period(vco1_freq, lfo_depth, mod_select[src_vco1], lfo_wave);
    assign vco2_period = mod_period(vco2_freq, lfo_depth, mod_select[src_vco2], lfo_wave);
    assign noise_rate  = mod_period(noise_freq, lfo_depth, mod_select[src_noise], lfo_wave);

    tone_oscillator #(.cnt_w(freq_w)) u_vco1 (
        .clk(clk), .arst_n(arst_n), .tick(tick), .period(vco1_period), .wave(vco1_wave)
    );

    tone_oscillator #(.cnt_w(freq_w)) u_vco2 (
        .clk(clk), .arst_n(arst_n), .tick(tick), .period(vco2_period), .wave(vco2_wave)
    );

    tone_oscillator #(.cnt_w(lfo_freq_w)) u_lfo (   // never modulated itself
        .clk(clk), .arst_n(arst_n), .tick(tick), .period(lfo_freq), .wave(lfo_wave)
    );

    noise_lfsr u_noise (
        .clk(clk), .arst_n(arst_n), .tick(tick), .rate(noise_rate), .noise(noise_bit)
    );

    assign src_bits[src_vco1]  = vco1_wave;
    assign src_bits[src_vco2]  = vco2_wave;
    assign src_bits[src_noise] = noise_bit;
    assign src_bits[src_lfo]   = lfo_wave;

    // mixer, one clk behind the sources
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            signal_out <= 1'b0;
        else
            signal_out <= ^(src_bits & mixer);   // disabled sources drop out
    end

endmodule

`default_nettype wire

//--- hw/sound_synth_pkg.sv
/*
 * Synthesizer side definitions
 *   bit position of each source in the mixer and mod fields
 *   noise LFSR width and feedback taps
 *   default clk cycles per tick
 */
`default_nettype none

package sound_synth_pkg;

    // mod_select uses the lower three positions only
    localparam int src_vco1  = 0;
    localparam int src_vco2  = 1;
    localparam int src_noise = 2;
    localparam int src_lfo   = 3;

    localparam int lfsr_w = 15;

    // x^15 + x^14 + 1, maximal length
    localparam logic [lfsr_w-1:0] lfsr_taps = 15'h6000;

    localparam int prescale_default = 4;             // clk cycles per tick

endpackage

`default_nettype wire

//--- hw/sound_unit_top.sv
/*
 * Top level of the sound unit
 *   register file on the 8 bit bus
 *   synthesizer fed from the decoded fields
 */
`default_nettype none

module sound_unit_top #(
    parameter int prescale = sound_synth_pkg::prescale_default
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [sound_bus_pkg::addr_w-1:0] addr,
    input  logic [sound_bus_pkg::data_w-1:0] data_in,
    input  logic                             re,
    input  logic                             we,
    output logic [sound_bus_pkg::data_w-1:0] data_out,
    output logic                             signal_out
);
    import sound_bus_pkg::*;

    // decoded register fields
    logic [freq_w-1:0]     vco1_freq;
    logic [freq_w-1:0]     vco2_freq;
    logic [freq_w-1:0]     noise_freq;
    logic [lfo_freq_w-1:0] lfo_freq;
    logic [depth_w-1:0]    lfo_depth;
    logic [mod_w-1:0]      mod_select;
    logic [mix_w-1:0]      mixer;

    sound_regs u_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .addr       (addr),
        .data_in    (data_in),
        .re         (re),
        .we         (we),
        .data_out   (data_out),
        .vco1_freq  (vco1_freq),
        .vco2_freq  (vco2_freq),
        .noise_freq (noise_freq),
        .lfo_freq   (lfo_freq),
        .lfo_depth  (lfo_depth),
        .mod_select (mod_select),
        .mixer      (mixer)
    );

    sound_synth #(.prescale(prescale)) u_synth (
        .clk        (clk),
        .arst_n     (arst_n),
        .vco1_freq  (vco1_freq),
        .vco2_freq  (vco2_freq),
        .noise_freq (noise_freq),
        .lfo_freq   (lfo_freq),
        .lfo_depth  (lfo_depth),
        .mod_select (mod_select),
        .mixer      (mixer),
        .signal_out (signal_out)
    );

endmodule

`default_nettype wire

//--- hw/tone_oscillator.sv
/*
 * Square wave oscillator
 *   down counter reloaded from period at each expiry
 *   wave toggles on the expiring tick
 */
`default_nettype none

module tone_oscillator #(
    parameter int cnt_w = 12
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             tick,     // one clk cycle per prescale
    input  logic [cnt_w-1:0] period,   // half period minus one, in ticks
    output logic             wave
);

    logic [cnt_w-1:0] cnt;             // ticks left in this half cycle

    // expiry reloads and toggles, so a half cycle spans period + 1 ticks
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= '0;                // first tick toggles right away
            wave <= 1'b0;
        end else if (tick) begin
            if (cnt == '0) begin
                cnt  <= period;        // period only sampled here
                wave <= ~wave;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- sound_unit.f
hw/sound_bus_pkg.sv
hw/sound_synth_pkg.sv
hw/sound_regs.sv
hw/tone_oscillator.sv
hw/noise_lfsr.sv
hw/sound_synth.sv
hw/sound_unit_top.sv
test/sound_unit_asserts.sv
test/sound_unit_tb.sv

//--- test/sound_unit_asserts.sv
/*
 * Concurrent checks bound into the sound unit top level
 *   readback zero while re is low
 *   signal_out quiet in reset, the cycle after, and while muted
 *   signal_out moves only after a tick or a mixer change
 */
`default_nettype none

module sound_unit_asserts (
    input logic                             clk,
    input logic                             arst_n,
    input logic                             re,
    input logic [sound_bus_pkg::data_w-1:0] data_out,
    input logic [sound_bus_pkg::mix_w-1:0]  mixer,
    input logic                             tick,
    input logic                             signal_out
);
    timeunit 1ns;
    timeprecision 1ps;

    bit   read_failed;                       // one flag per property
    bit   reset_failed;
    bit   mute_failed;
    bit   edge_failed;
    logic any_failed;

    assign any_failed = read_failed | reset_failed | mute_failed | edge_failed;

    read_zero: assert property (@(posedge clk) !re |-> data_out == '0)
        else begin
            read_failed = 1'b1;
            $error("data_out nonzero while re is low");
        end

    reset_quiet: assert property (@(posedge clk) (!arst_n || !$past(arst_n)) |-> !signal_out)
        else begin
            reset_failed = 1'b1;
            $error("signal_out high in reset or the cycle after");
        end

    // mixer seen one cycle earlier feeds the register
    mute_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        (mixer == '0 && $past(mixer) == '0) |-> !signal_out)
        else begin
            mute_failed = 1'b1;
            $error("signal_out high while mixer is 0");
        end

    // tick, then source edge, then signal_out edge
    tick_edge: assert property (@(posedge clk) disable iff (!arst_n)
        (signal_out != $past(signal_out)) |->
            ($past(tick, 2) || $past(mixer) != $past(mixer, 2)))
        else begin
            edge_failed = 1'b1;
            $error("signal_out changed without a preceding tick");
        end

endmodule

bind sound_unit_top sound_unit_asserts checks (
    .clk        (clk),
    .arst_n     (arst_n),
    .re         (re),
    .data_out   (data_out),
    .mixer      (mixer),
    .tick       (u_synth.tick),
    .signal_out (signal_out)
);

`default_nettype wire

//--- test/sound_unit_tb.sv
/*
 * Testbench of the sound unit
 *   clock, reset and bus tasks with a register model
 *   readback, mute, tone, noise and LFO modulation tests
 *   cycle limit and final result
 */
`default_nettype none

module sound_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import sound_bus_pkg::*;
    import sound_synth_pkg::*;

    localparam int max_cycles = 200000;      // bound on the whole run
    localparam int ticks_clk  = 4;           // clk cycles per tick in the dut

    logic              clk;
    logic              arst_n;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data_in;
    logic              re;
    logic              we;
    logic [data_w-1:0] data_out;
    logic              signal_out;

    logic [data_w-1:0] model [0:10];         // expected field per mapped address
    logic [31:0]       rng;
    int                cycle_cnt = 0;

    sound_unit_top #(.prescale(ticks_clk)) dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .addr       (addr),
        .data_in    (data_in),
        .re         (re),
        .we         (we),
        .data_out   (data_out),
        .signal_out (signal_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;              // 20 ns period
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles)
            stop_with_error("run did not finish within the cycle limit");
    end

    always @(negedge clk) begin
        if (dut.checks.any_failed)           // flag from the bound checks
            stop_with_error("a bound assertion on the dut failed");
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // stored bits per address from the field widths
    function automatic logic [data_w-1:0] field_mask(input logic [addr_w-1:0] a);
        case (a)
            addr_vco1_lo, addr_vco2_lo, addr_noise_lo, addr_lfo_lo: return '1;
            addr_vco1_hi, addr_vco2_hi, addr_noise_hi: return data_w'((1 << (freq_w - 8)) - 1);
            addr_lfo_hi:  return data_w'((1 << (lfo_freq_w - 8)) - 1);
            addr_depth:   return data_w'((1 << depth_w) - 1);
            addr_mod_sel: return data_w'((1 << mod_w) - 1);
            addr_mixer:   return data_w'((1 << mix_w) - 1);
            default:      return '0;             // unmapped
        endcase
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        foreach (model[i])
            model[i] = '0;
    endtask

    task automatic write_reg(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
        @(posedge clk);
        addr    <= a;
        data_in <= d;
        we      <= 1'b1;
        @(posedge clk);                      // stored at this edge
        we      <= 1'b0;
        if (a <= addr_mixer)
            model[a[3:0]] = d & field_mask(a);
    endtask

    task automatic read_check(input logic [addr_w-1:0] a);
        logic [data_w-1:0] expected;
        expected = (a <= addr_mixer) ? model[a[3:0]] : '0;
        @(posedge clk);
        addr <= a;
        re   <= 1'b1;
        @(negedge clk);                      // readback is combinational
        assert (data_out == expected) else begin
            stop_with_error($sformatf("Fail data_out at %h: got %h, expected %h",
                                      a, data_out, expected));
        end
        @(posedge clk);
        re <= 1'b0;
    endtask

    // cycles from this negedge up to the next signal_out edge
    task automatic time_to_edge(output int len);
        logic start;
        start = signal_out;
        len = 0;
        do begin
            @(negedge clk);
            len++;
        end while (signal_out == start);
    endtask

    task automatic check_tone(input int freq);
        int expected;
        int len;
        expected = (freq + 1) * ticks_clk;
        @(negedge clk);
        time_to_edge(len);                   // align
        time_to_edge(len);                   // may still be partial
        repeat (8) begin
            time_to_edge(len);
            assert (len == expected) else begin
                stop_with_error($sformatf("Fail half_period: got %h, expected %h",
                                          len, expected));
            end
        end
    endtask

    task automatic mute_test();
        write_reg(addr_vco1_lo, 8'd5);
        write_reg(addr_vco2_lo, 8'd7);
        write_reg(addr_noise_lo, 8'd3);
        write_reg(addr_lfo_lo, 8'd9);
        write_reg(addr_mixer, 8'h00);
        repeat (2000) begin
            @(negedge clk);
            assert (signal_out == 1'b0) else begin
                stop_with_error($sformatf("Fail signal_out: got %h, expected %h",
                                          signal_out, 1'b0));
            end
        end
    endtask

    task automatic tone_test(input logic [addr_w-1:0] lo_addr, input int src);
        int freq;
        freq = 4 + int'(next_random() % 60);      // keeps the hi byte at 0
        write_reg(lo_addr, data_w'(freq));
        write_reg(lo_addr + 8'd1, 8'h00);
        write_reg(addr_mod_sel, 8'h00);
        write_reg(addr_mixer, data_w'(1 << src)); // single source
        check_tone(freq);
    endtask

    task automatic noise_test();
        int rate;
        int step;
        int len;
        int edges;
        logic last;
        rate = 1 + int'(next_random() % 15);      // step longer than one tick
        step = (rate + 1) * ticks_clk;            // clk cycles per LFSR step
        write_reg(addr_noise_lo, data_w'(rate));
        write_reg(addr_noise_hi, 8'h00);
        write_reg(addr_mod_sel, 8'h00);
        write_reg(addr_mixer, data_w'(1 << src_noise));
        edges = 0;
        len = 0;
        @(negedge clk);
        last = signal_out;
        repeat (2000) begin
            @(negedge clk);
            len++;
            if (signal_out != last) begin
                // first edge can come from the mixer write
                assert (edges < 2 || len % step == 0) else begin
                    stop_with_error($sformatf("Fail noise_interval: got %h, step %h",
                                              len, step));
                end
                edges++;
                len = 0;
                last = signal_out;
            end
        end
        assert (edges > 1) else begin
            stop_with_error("noise output never toggled in 2000 cycles");
        end
    endtask

    // lfo half cycle of 256 clk exceeds the long vco half cycle
    task automatic mod_test();
        int freq;
        int len;
        int short_len;
        int long_len;
        bit seen_short;
        bit seen_long;
        freq = 20 + int'(next_random() % 16);
        short_len = (freq + 1) * ticks_clk;
        long_len  = (freq + (freq >> 1) + 1) * ticks_clk;   // depth 1
        write_reg(addr_lfo_lo, 8'd63);
        write_reg(addr_lfo_hi, 8'h00);
        write_reg(addr_vco1_lo, data_w'(freq));
        write_reg(addr_vco1_hi, 8'h00);
        write_reg(addr_depth, 8'd1);
        write_reg(addr_mod_sel, data_w'(1 << src_vco1));
        write_reg(addr_mixer, data_w'(1 << src_vco1));
        seen_short = 1'b0;
        seen_long  = 1'b0;
        @(negedge clk);
        time_to_edge(len);
        time_to_edge(len);
        repeat (8) begin
            time_to_edge(len);
            assert (len == short_len || len == long_len) else begin
                stop_with_error($sformatf("Fail half_period: got %h, expected %h or %h",
                                          len, short_len, long_len));
            end
            if (len == short_len)
                seen_short = 1'b1;
            if (len == long_len)
                seen_long = 1'b1;
        end
        assert (seen_short && seen_long) else begin
            stop_with_error("modulated VCO1 did not show both half periods");
        end
    endtask

    initial begin
        arst_n  = 1'b0;
        addr    = '0;
        data_in = '0;
        re      = 1'b0;
        we      = 1'b0;
        rng     = 32'd98125;
        apply_reset();
        for (int a = 0; a <= 10; a++)
            read_check(addr_w'(a));               // all zero after reset
        for (int a = 0; a <= 10; a++)
            write_reg(addr_w'(a), data_w'(next_random()));
        for (int a = 11; a < 256; a++)
            write_reg(addr_w'(a), data_w'(next_random()));
        for (int a = 0; a < 256; a++)
            read_check(addr_w'(a));
        apply_reset();                            // clears long counts from random fields
        mute_test();
        tone_test(addr_vco1_lo, src_vco1);
        tone_test(addr_vco2_lo, src_vco2);
        tone_test(addr_lfo_lo, src_lfo);
        noise_test();
        mod_test();
        repeat (4) @(posedge clk);
        if (dut.checks.any_failed) begin
            stop_with_error("a bound assertion on the dut failed");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire
